//--- rtl/fdiv_format_pkg.sv
`default_nettype none

package fdiv_format_pkg;

	localparam int operand_w = 65; // sign, exponent, fraction
	localparam int exp_w = 12;
	localparam int frac_w = 52;
	localparam int rexp_w = 14; // signed internal exponent

	localparam int rem_w = 57;
	localparam int quo_w = 55;
	localparam int mant_w = 54;

	localparam int div_steps = 55;
	localparam int sqrt_steps = 54;

	localparam int result_bias = 1023;
	localparam int sqrt_exp_offset = 2045;

	// divisor stand-in for square root
	localparam logic [operand_w-1:0] sqrt_dummy_divisor = {1'b0, {exp_w{1'b1}}, {frac_w{1'b0}}};

endpackage

`default_nettype wire

//--- rtl/fdiv_types_pkg.sv
`default_nettype none

package fdiv_types_pkg;

	typedef enum logic [1:0] {
		op_none,
		op_div,
		op_sqrt
	} fdiv_op_t;

	typedef enum logic [1:0] {
		st_idle,
		st_iterate,
		st_normalize,
		st_done
	} fdiv_state_t;

	// one-hot, neg_inf is bit 0 and qnan bit 9
	typedef struct packed {
		logic qnan;
		logic snan;
		logic pos_inf;
		logic pos_norm;
		logic pos_sub;
		logic pos_zero;
		logic neg_zero;
		logic neg_sub;
		logic neg_norm;
		logic neg_inf;
	} fp_class_t;

	typedef struct packed {
		fdiv_op_t op; // one-cycle strobe
		logic [fdiv_format_pkg::operand_w-1:0] data1;
		logic [fdiv_format_pkg::operand_w-1:0] data2;
		fp_class_t class1;
		fp_class_t class2;
	} fdiv_req_t;

	typedef struct packed {
		logic snan;
		logic qnan;
		logic dbz;
		logic inf;
		logic zero;
	} fdiv_flags_t;

	typedef struct packed {
		logic sign;
		logic signed [fdiv_format_pkg::rexp_w-1:0] exponent;
		logic [fdiv_format_pkg::mant_w-1:0] mantissa;
		logic [2:0] grs;
		fdiv_flags_t flags;
	} fdiv_result_t;

endpackage

`default_nettype wire

//--- rtl/fdiv_classify.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_classify (
	input logic clock,
	input logic reset,
	input logic start_i,
	input fdiv_types_pkg::fdiv_req_t req_i,
	output fdiv_types_pkg::fdiv_flags_t flags_o,
	output logic sign_o,
	output logic signed [fdiv_format_pkg::rexp_w-1:0] exponent_o,
	output logic is_sqrt_o
);
	import fdiv_format_pkg::*;
	import fdiv_types_pkg::*;

	logic is_sqrt;
	logic [operand_w-1:0] opb;
	fp_class_t ca;
	fp_class_t cb;
	logic a_zero, a_inf, a_fin_nz;
	logic b_zero, b_inf, b_fin;
	fdiv_flags_t flags;
	logic signed [rexp_w-1:0] ea, eb, sqrt_diff, exponent;

	assign is_sqrt = req_i.op == op_sqrt;
	assign opb = is_sqrt ? sqrt_dummy_divisor : req_i.data2;
	assign ca = req_i.class1;
	assign cb = is_sqrt ? '0 : req_i.class2; // no class for the stand-in

	assign a_zero = ca.neg_zero | ca.pos_zero;
	assign a_inf = ca.neg_inf | ca.pos_inf;
	assign a_fin_nz = ca.neg_norm | ca.neg_sub | ca.pos_sub | ca.pos_norm;
	assign b_zero = cb.neg_zero | cb.pos_zero;
	assign b_inf = cb.neg_inf | cb.pos_inf;
	assign b_fin = cb.neg_norm | cb.neg_sub | b_zero | cb.pos_sub | cb.pos_norm;

	always_comb begin
		flags.snan = ca.snan | cb.snan | (a_zero & b_zero) | (a_inf & b_inf);
		if (is_sqrt && (ca.neg_inf | ca.neg_norm | ca.neg_sub)) begin
			flags.snan = 1'b1; // root of a negative
		end
		flags.qnan = ~flags.snan & (ca.qnan | cb.qnan);
		flags.inf = (a_inf & b_fin) | (is_sqrt & ca.pos_inf);
		flags.dbz = ~flags.inf & b_zero & a_fin_nz;
		flags.zero = a_zero | b_inf;
	end

	assign ea = $signed({{(rexp_w-exp_w){1'b0}}, req_i.data1[operand_w-2 -: exp_w]});
	assign eb = $signed({{(rexp_w-exp_w){1'b0}}, opb[operand_w-2 -: exp_w]});
	assign sqrt_diff = ea - $signed(rexp_w'(sqrt_exp_offset));
	assign exponent = is_sqrt ? (sqrt_diff >>> 1) : (ea - eb);

	always_ff @(posedge clock) begin
		if (!reset) begin
			flags_o <= '0;
			is_sqrt_o <= 1'b0;
		end else if (start_i) begin
			flags_o <= flags;
			is_sqrt_o <= is_sqrt;
		end
	end

	always_ff @(posedge clock) begin
		if (start_i) begin
			sign_o <= req_i.data1[operand_w-1] ^ opb[operand_w-1];
			exponent_o <= exponent;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fdiv_control.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_control (
	input logic clock,
	input logic reset,
	input fdiv_types_pkg::fdiv_op_t op_i,
	output logic start_o,
	output logic step_o,
	output logic [5:0] step_idx_o,
	output logic norm_o,
	output logic ready_o
);
	import fdiv_format_pkg::*;
	import fdiv_types_pkg::*;

	fdiv_state_t state_q;
	logic [5:0] idx_q;

	// requests outside idle are dropped
	assign start_o = (state_q == st_idle) && ((op_i == op_div) || (op_i == op_sqrt));

	always_ff @(posedge clock) begin
		if (!reset) begin
			state_q <= st_idle;
			idx_q <= '0;
		end else begin
			case (state_q)
				st_idle: begin
					if (start_o) begin
						state_q <= st_iterate;
						idx_q <= (op_i == op_sqrt) ? 6'(sqrt_steps - 1) : 6'(div_steps - 1);
					end
				end
				st_iterate: begin
					if (idx_q == '0) begin
						state_q <= st_normalize;
					end else begin
						idx_q <= idx_q - 6'd1;
					end
				end
				st_normalize: state_q <= st_done;
				default: state_q <= st_idle; // st_done
			endcase
		end
	end

	assign step_o = state_q == st_iterate;
	assign step_idx_o = idx_q;
	assign norm_o = state_q == st_normalize;
	assign ready_o = state_q == st_done;

endmodule

`default_nettype wire

//--- rtl/fdiv_recurrence.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_recurrence (
	input logic clock,
	input logic reset,
	input logic start_i,
	input fdiv_types_pkg::fdiv_op_t op_i,
	input logic [fdiv_format_pkg::operand_w-1:0] data1_i,
	input logic [fdiv_format_pkg::operand_w-1:0] data2_i,
	input logic step_i,
	input logic [5:0] step_idx_i,
	output logic [fdiv_format_pkg::quo_w-1:0] quotient_o,
	output logic [fdiv_format_pkg::rem_w-1:0] remainder_o
);
	import fdiv_format_pkg::*;
	import fdiv_types_pkg::*;

	logic sqrt_q;
	logic [rem_w-1:0] rem_q, div_q;
	logic [quo_w-1:0] quo_q;
	logic [rem_w-1:0] rem_load, rem_sh, trial, diff;

	always_comb begin
		rem_load = {(rem_w-frac_w)'(1), data1_i[frac_w-1:0]};
		if (op_i == op_sqrt && !data1_i[frac_w]) begin
			rem_load = {rem_load[rem_w-2:0], 1'b0}; // even exponent
		end
	end

	assign rem_sh = {rem_q[rem_w-2:0], 1'b0};
	// partial root with the trial bit appended
	assign trial = sqrt_q ? ({1'b0, quo_q, 1'b0} | (rem_w'(1) << step_idx_i)) : div_q;
	assign diff = rem_sh - trial;

	always_ff @(posedge clock) begin
		if (!reset) begin
			sqrt_q <= 1'b0;
		end else if (start_i) begin
			sqrt_q <= op_i == op_sqrt;
		end
	end

	always_ff @(posedge clock) begin
		if (start_i) begin
			rem_q <= rem_load;
			div_q <= (op_i == op_sqrt) ? '0 :
				{(rem_w-frac_w-1)'(1), data2_i[frac_w-1:0], 1'b0};
			quo_q <= '0;
		end else if (step_i) begin
			if (!diff[rem_w-1]) begin
				rem_q <= diff;
				quo_q <= quo_q | (quo_w'(1) << step_idx_i);
			end else begin
				rem_q <= rem_sh; // restore
			end
		end
	end

	assign quotient_o = quo_q;
	assign remainder_o = rem_q;

endmodule

`default_nettype wire

//--- rtl/fdiv_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_normalize (
	input logic clock,
	input logic reset,
	input logic norm_i,
	input logic [fdiv_format_pkg::quo_w-1:0] quotient_i,
	input logic [fdiv_format_pkg::rem_w-1:0] remainder_i,
	input logic sign_i,
	input logic signed [fdiv_format_pkg::rexp_w-1:0] exponent_i,
	input logic is_sqrt_i,
	input fdiv_types_pkg::fdiv_flags_t flags_i,
	output fdiv_types_pkg::fdiv_result_t result_o
);
	import fdiv_format_pkg::*;
	import fdiv_types_pkg::*;

	// quotient, remainder and room for the subnormal shift
	localparam int wide_w = quo_w + rem_w - 1 + mant_w;
	localparam logic signed [rexp_w-1:0] max_shift = rexp_w'(mant_w);

	logic lead_shift;
	logic [wide_w-1:0] wide;
	logic signed [rexp_w-1:0] exp_b;
	logic signed [rexp_w-1:0] rshift_full;
	logic [5:0] rshift;
	fdiv_result_t result;

	// the root never reaches the top quotient bit
	assign lead_shift = is_sqrt_i | ~quotient_i[quo_w-1];

	always_comb begin
		wide = {quotient_i, remainder_i[rem_w-2:0], {mant_w{1'b0}}};
		if (lead_shift) begin
			wide = {wide[wide_w-2:0], 1'b0};
		end

		exp_b = exponent_i + rexp_w'(result_bias) - rexp_w'(lead_shift);
		rshift_full = '0;
		if (exp_b <= 0) begin
			if (exp_b > -max_shift) begin
				rshift_full = rexp_w'(1) - exp_b;
			end else begin
				rshift_full = max_shift;
			end
			exp_b = '0;
		end
		rshift = rshift_full[5:0];
		wide = wide >> rshift;

		result.sign = sign_i;
		result.exponent = exp_b;
		result.mantissa = {1'b0, wide[wide_w-1 -: mant_w-1]};
		result.grs = {wide[wide_w-mant_w -: 2], |wide[wide_w-mant_w-2:0]};
		result.flags = flags_i;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			result_o <= '0;
		end else if (norm_i) begin
			result_o <= result; // held until the next operation
		end
	end

endmodule

`default_nettype wire

//--- rtl/fdiv_top.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_top (
	input logic clock,
	input logic reset,
	input fdiv_types_pkg::fdiv_req_t req_i,
	output fdiv_types_pkg::fdiv_result_t result_o,
	output logic ready_o
);
	import fdiv_format_pkg::*;
	import fdiv_types_pkg::*;

	logic start;
	logic step;
	logic [5:0] step_idx;
	logic norm;
	fdiv_flags_t flags;
	logic sign;
	logic signed [rexp_w-1:0] exponent;
	logic is_sqrt;
	logic [quo_w-1:0] quotient;
	logic [rem_w-1:0] remainder;

	fdiv_control control0 (
		.clock(clock),
		.reset(reset),
		.op_i(req_i.op),
		.start_o(start),
		.step_o(step),
		.step_idx_o(step_idx),
		.norm_o(norm),
		.ready_o(ready_o)
	);

	fdiv_classify classify0 (
		.clock(clock),
		.reset(reset),
		.start_i(start),
		.req_i(req_i),
		.flags_o(flags),
		.sign_o(sign),
		.exponent_o(exponent),
		.is_sqrt_o(is_sqrt)
	);

	fdiv_recurrence recurrence0 (
		.clock(clock),
		.reset(reset),
		.start_i(start),
		.op_i(req_i.op),
		.data1_i(req_i.data1),
		.data2_i(req_i.data2),
		.step_i(step),
		.step_idx_i(step_idx),
		.quotient_o(quotient),
		.remainder_o(remainder)
	);

	fdiv_normalize normalize0 (
		.clock(clock),
		.reset(reset),
		.norm_i(norm),
		.quotient_i(quotient),
		.remainder_i(remainder),
		.sign_i(sign),
		.exponent_i(exponent),
		.is_sqrt_i(is_sqrt),
		.flags_i(flags),
		.result_o(result_o)
	);

endmodule

`default_nettype wire

//--- test/fdiv_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_assertions (
	input logic clock,
	input logic reset,
	input fdiv_types_pkg::fdiv_op_t op_i,
	input logic start_i,
	input logic ready_i
);
	import fdiv_format_pkg::*;
	import fdiv_types_pkg::*;

	localparam int div_latency = div_steps + 2; // steps, normalize, done
	localparam int sqrt_latency = sqrt_steps + 2;

	logic busy_q; // between start and ready

	always_ff @(posedge clock) begin
		if (!reset) begin
			busy_q <= 1'b0;
		end else if (start_i) begin
			busy_q <= 1'b1;
		end else if (ready_i) begin
			busy_q <= 1'b0;
		end
	end

	a_ready_pulse: assert property (@(posedge clock) disable iff (!reset)
		ready_i |=> !ready_i)
		else $error("ready_o stayed high for more than one cycle");

	a_start_idle: assert property (@(posedge clock) disable iff (!reset)
		start_i |-> !busy_q)
		else $error("start_o raised while an operation was in progress");

	a_div_latency: assert property (@(posedge clock) disable iff (!reset)
		(start_i && op_i == op_div) |-> ##div_latency ready_i)
		else $error("ready_o missing after a division");

	a_sqrt_latency: assert property (@(posedge clock) disable iff (!reset)
		(start_i && op_i == op_sqrt) |-> ##sqrt_latency ready_i)
		else $error("ready_o missing after a square root");

endmodule

`default_nettype wire

//--- test/fdiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_tb;
	import fdiv_types_pkg::*;

	localparam int div_latency = 57;
	localparam int sqrt_latency = 56;
	localparam int timeout_cycles = 400 * 62 + 100;

	logic clock = 1'b0;
	logic reset;
	fdiv_req_t req;
	fdiv_result_t result;
	logic ready;
	int cycle_count = 0;
	int checks = 0;
	int errors = 0;
	int test_errors = 0;

	fdiv_top dut0 (
		.clock(clock),
		.reset(reset),
		.req_i(req),
		.result_o(result),
		.ready_o(ready)
	);

	bind fdiv_control fdiv_assertions asrt0 (
		.clock(clock),
		.reset(reset),
		.op_i(op_i),
		.start_i(start_o),
		.ready_i(ready_o)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	function automatic logic [64:0] with_fields(input logic sign, input int exp);
		logic [63:0] bits;
		bits = {$urandom, $urandom};
		return {sign, 12'(exp), bits[51:0]};
	endfunction

	// 0 zero, 1 inf, 2 qnan, 3 snan, 4 subnormal, else normal
	function automatic logic [64:0] make_operand(input int kind, input logic sign);
		logic [64:0] x;
		case (kind)
			0: x = with_fields(sign, rand_range(0, 511));
			1: x = with_fields(sign, rand_range(3072, 3583));
			2, 3: begin
				x = with_fields(sign, rand_range(3584, 4095));
				x[51] = kind == 2; // quiet bit
			end
			4: x = with_fields(sign, rand_range(512, 1025));
			default: x = with_fields(sign, rand_range(1026, 3071));
		endcase
		return x;
	endfunction

	function automatic fp_class_t class_of(input logic [64:0] x);
		fp_class_t c;
		logic [11:0] e;
		c = '0;
		e = x[63:52];
		if (e[11:9] == 3'b111) begin
			c.qnan = x[51];
			c.snan = !x[51];
		end else if (e[11:9] == 3'b110) begin
			c.neg_inf = x[64];
			c.pos_inf = !x[64];
		end else if (e[11:9] == 3'b000) begin
			c.neg_zero = x[64];
			c.pos_zero = !x[64];
		end else if (e < 12'h402) begin
			c.neg_sub = x[64];
			c.pos_sub = !x[64];
		end else begin
			c.neg_norm = x[64];
			c.pos_norm = !x[64];
		end
		return c;
	endfunction

	task automatic make_request(input int test, input int idx, output fdiv_req_t r);
		int ea;
		r = '0;
		r.op = ($urandom % 2) ? op_sqrt : op_div;
		case (test)
			0: begin
				r.op = op_div;
				r.data1 = with_fields(1'($urandom), rand_range(1500, 2500));
				r.data2 = with_fields(1'($urandom), rand_range(1500, 2500));
			end
			1: begin
				r.op = op_sqrt;
				ea = rand_range(513, 1535) * 2 + idx % 2; // both parities
				r.data1 = with_fields(1'b0, ea);
				r.data2 = make_operand(5, 1'($urandom));
			end
			2: begin
				r.op = op_div;
				ea = rand_range(1026, 1100);
				r.data1 = with_fields(1'($urandom), ea);
				r.data2 = with_fields(1'($urandom), ea + 1023 + rand_range(0, 60));
			end
			3: begin
				r.data1 = make_operand(rand_range(0, 5), 1'($urandom));
				r.data2 = make_operand(rand_range(0, 5), 1'($urandom));
			end
			default: begin
				r.data1 = with_fields(r.op == op_div && 1'($urandom), rand_range(1500, 2500));
				r.data2 = with_fields(1'($urandom), rand_range(1500, 2500));
			end
		endcase
		r.class1 = class_of(r.data1);
		r.class2 = class_of(r.data2);
	endtask

	function automatic logic [127:0] int_sqrt(input logic [127:0] x);
		logic [127:0] root;
		logic [127:0] cand;
		int b;
		root = '0;
		for (b = 63; b >= 0; b--) begin
			cand = root | (128'd1 << b);
			if (cand * cand <= x) begin
				root = cand;
			end
		end
		return root;
	endfunction

	function automatic fdiv_flags_t model_flags(input fdiv_req_t r);
		fp_class_t a;
		fp_class_t b;
		logic sq;
		logic a_zero, a_inf, a_finite_nz, a_neg_nz, b_zero, b_inf, b_finite;
		fdiv_flags_t f;
		sq = r.op == op_sqrt;
		a = r.class1;
		b = sq ? fp_class_t'(0) : r.class2; // stand-in divisor has no class
		a_zero = a.pos_zero || a.neg_zero;
		a_inf = a.pos_inf || a.neg_inf;
		a_finite_nz = a.pos_norm || a.neg_norm || a.pos_sub || a.neg_sub;
		a_neg_nz = a.neg_norm || a.neg_sub || a.neg_inf;
		b_zero = b.pos_zero || b.neg_zero;
		b_inf = b.pos_inf || b.neg_inf;
		b_finite = b_zero || b.pos_norm || b.neg_norm || b.pos_sub || b.neg_sub;
		f.snan = a.snan || b.snan || (a_zero && b_zero) || (a_inf && b_inf) || (sq && a_neg_nz);
		f.qnan = !f.snan && (a.qnan || b.qnan);
		f.inf = (a_inf && b_finite) || (sq && a.pos_inf);
		f.dbz = !f.inf && b_zero && a_finite_nz;
		f.zero = a_zero || b_inf;
		return f;
	endfunction

	task automatic normalize_model(input logic [54:0] q, input logic rem_nz, input int exp_in,
			output logic [53:0] mant, output logic [2:0] grs, output logic [13:0] exp_out);
		logic [108:0] v;
		int e;
		int sh;
		v = {q, 54'b0};
		e = exp_in + 1023;
		if (!q[54]) begin
			v = v << 1;
			e = e - 1;
		end
		sh = 0;
		if (e <= 0) begin
			sh = (1 - e > 54) ? 54 : 1 - e;
			e = 0;
		end
		v = v >> sh;
		mant = {1'b0, v[108:56]};
		grs = {v[55], v[54], (|v[53:0]) | rem_nz};
		exp_out = 14'(e);
	endtask

	task automatic model_result(input fdiv_req_t r, output fdiv_result_t e);
		logic [127:0] ma, mb, num, q, rem;
		int ea, ex;
		ea = int'(r.data1[63:52]);
		ma = {75'b0, 1'b1, r.data1[51:0]};
		if (r.op == op_sqrt) begin
			if (!r.data1[52]) begin
				ma = ma << 1;
			end
			num = ma << 54;
			q = int_sqrt(num);
			rem = num - q * q;
			ex = (ea - 2045) >>> 1;
			e.sign = r.data1[64];
		end else begin
			mb = {75'b0, 1'b1, r.data2[51:0]};
			num = ma << 54;
			q = num / mb;
			rem = num % mb;
			ex = ea - int'(r.data2[63:52]);
			e.sign = r.data1[64] ^ r.data2[64];
		end
		normalize_model(q[54:0], rem != 0, ex, e.mantissa, e.grs, e.exponent);
		e.flags = model_flags(r);
	endtask

	task automatic run_request(input fdiv_req_t r, input fdiv_req_t busy, input int busy_at,
			output fdiv_result_t res, output int cycles);
		cycles = 0;
		@(posedge clock);
		req <= r;
		@(posedge clock);
		req.op <= op_none; // accepted on this edge
		do begin
			@(negedge clock);
			cycles++;
			if (!ready) begin
				@(posedge clock);
				if (cycles == busy_at) begin
					req <= busy; // strobe while busy
				end else begin
					req.op <= op_none;
				end
			end
		end while (!ready);
		res = result;
	endtask

	initial begin
		fdiv_req_t r, busy;
		fdiv_result_t got, want;
		int t, i, n, cycles, busy_at;
		void'($urandom(32'h3ed1));
		req = '0;
		reset = 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b1;
		for (t = 0; t < 5; t++) begin
			test_errors = 0;
			n = (t == 2) ? 60 : ((t == 4) ? 40 : 100);
			for (i = 0; i < n; i++) begin
				make_request(t, i, r);
				make_request(4, i, busy);
				busy_at = (t == 4) ? rand_range(2, 40) : 0;
				model_result(r, want);
				run_request(r, busy, busy_at, got, cycles);
				check_value("sign", got.sign, want.sign);
				check_value("exponent", got.exponent, want.exponent);
				check_value("mantissa", got.mantissa, want.mantissa);
				check_value("grs", got.grs, want.grs);
				check_value("flags", got.flags, want.flags);
				check_value("latency", cycles, (r.op == op_sqrt) ? sqrt_latency : div_latency);
				repeat ($urandom % 4) @(posedge clock);
			end
			$display("test %0d: %0d requests, %0d errors", t + 1, n, test_errors);
		end
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
rtl/fdiv_format_pkg.sv
rtl/fdiv_types_pkg.sv
rtl/fdiv_classify.sv
rtl/fdiv_control.sv
rtl/fdiv_recurrence.sv
rtl/fdiv_normalize.sv
rtl/fdiv_top.sv
test/fdiv_assertions.sv
test/fdiv_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fdiv testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fdiv_tb -f list.f -o fdiv_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/fdiv_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
